// File: rtl/ttt_defines.svh
`ifndef TTT_DEFINES_SVH
`define TTT_DEFINES_SVH

// Board geometry
`define TTT_CELLS    9           // 3x3 board

// Tile block size in pixels
`define TTT_CELL_W   4
`define TTT_CELL_H   8

// Spacing between cell origins
`define TTT_PITCH_X  8'd6
`define TTT_PITCH_Y  7'd10

// Top left corner of the board on a 160x120 screen
`define TTT_ORG_X    8'd60
`define TTT_ORG_Y    7'd40

// Pixel coordinate widths
`define TTT_X_W      8
`define TTT_Y_W      7

// ASCII key codes
`define TTT_KEY_ENTER 7'h0A      // Line feed, as sent by the keyboard path
`define TTT_KEY_R     7'h72      // 'r'
`define TTT_KEY_B     7'h62      // 'b'
`define TTT_KEY_ONE   7'h31      // '1', digits follow in order

// Pixel colours, RGB one bit each
`define TTT_COL_RED   3'b100
`define TTT_COL_BLUE  3'b001

`endif

// File: rtl/ttt_pkg.sv
`default_nettype none

`include "ttt_defines.svh"

package ttt_pkg;

	// Tile in a cell, red and blue each own one bit
	typedef enum logic [1:0]
	{
		EMPTY = 2'b00,
		BLUE  = 2'b01,
		RED   = 2'b10
	} tile_t;

	// Same two bits seen as separate colour flags
	typedef struct packed
	{
		logic red;
		logic blue;
	} cell_bits_t;

	// Board and plotter read a tile, the judge reads the bits
	typedef union packed
	{
		tile_t      tile;
		cell_bits_t bits;
	} cell_t;

	typedef cell_t [`TTT_CELLS-1:0] board_t;   // 18 bits

	typedef logic [3:0] cell_idx_t;            // 0 to 8

	// One move, cell and tile
	typedef struct packed
	{
		cell_idx_t index;
		tile_t     tile;
	} move_t;

	typedef enum logic { P1 = 1'b0, P2 = 1'b1 } player_t;

	typedef enum logic [1:0] { PLAYING, P1_WINS, P2_WINS, TIE } result_t;

	// One pixel for the frame buffer
	typedef struct packed
	{
		logic [`TTT_X_W-1:0] x;
		logic [`TTT_Y_W-1:0] y;
		logic [2:0]          colour;
	} plot_t;

endpackage

`default_nettype wire

// File: rtl/key_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "ttt_defines.svh"

module key_decoder
(
	input  wire logic            clock,
	input  wire logic            resetn,
	input  wire logic [6:0]      key_code,     // Decoded ASCII
	input  wire logic            key_strobe,   // One cycle per key
	input  wire logic            clear,        // Move accepted, drop pending parts
	output ttt_pkg::move_t       pending,
	output logic                 commit
);

	logic [6:0] digit_off;   // Key minus '1', wraps high below '1'
	logic       idx_valid;
	logic       tile_valid;

	assign digit_off = key_code - `TTT_KEY_ONE;

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			pending    <= '0;   // Index 0, tile EMPTY
			idx_valid  <= 1'b0;
			tile_valid <= 1'b0;
			commit     <= 1'b0;
		end
		else
		begin
			commit <= 1'b0;   // Pulse only
			if (clear)
			begin
				idx_valid  <= 1'b0;
				tile_valid <= 1'b0;
			end
			// A key in the clear cycle still counts for the next move
			if (key_strobe)
			begin
				if (digit_off < `TTT_CELLS)
				begin
					pending.index <= digit_off[3:0];   // '1'..'9' -> 0..8
					idx_valid     <= 1'b1;
				end
				else if (key_code == `TTT_KEY_R)
				begin
					pending.tile <= ttt_pkg::RED;
					tile_valid   <= 1'b1;
				end
				else if (key_code == `TTT_KEY_B)
				begin
					pending.tile <= ttt_pkg::BLUE;
					tile_valid   <= 1'b1;
				end
				else if (key_code == `TTT_KEY_ENTER)
					commit <= idx_valid && tile_valid;   // Both halves needed
				// Any other character is dropped
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/game_control.sv
`timescale 1ns/100ps
`default_nettype none

module game_control
(
	input  wire logic            clock,
	input  wire logic            resetn,
	input  wire logic            commit,      // Enter with cell and tile pending
	input  wire ttt_pkg::move_t  pending,
	input  wire logic            cell_busy,   // Pending cell already holds a tile
	input  wire logic            lost,        // Some line is three equal tiles
	input  wire logic            tie,         // Board full, no line
	input  wire logic            done,        // Last pixel of the block
	output logic                 place,
	output logic                 clear,
	output logic                 start,
	output ttt_pkg::player_t     turn,
	output ttt_pkg::result_t     result
);

	// Phases
	localparam logic [1:0] PH_WAIT  = 2'd0;   // Waiting for a legal move
	localparam logic [1:0] PH_DRAW  = 2'd1;   // Plotter busy with the tile
	localparam logic [1:0] PH_JUDGE = 2'd2;   // Board settled, read the judge

	logic [1:0] phase;
	logic       legal;

	// Only a free cell, in a running game
	assign legal = commit && (phase == PH_WAIT) && (result == ttt_pkg::PLAYING)
		&& !cell_busy;

	// Board write, block draw and key flush all happen on the commit cycle
	assign place = legal;
	assign start = legal;
	assign clear = legal;

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			phase  <= PH_WAIT;
			turn   <= ttt_pkg::P1;
			result <= ttt_pkg::PLAYING;
		end
		else
		begin
			case (phase)
				PH_WAIT:
				begin
					if (legal)
						phase <= PH_DRAW;
				end
				PH_DRAW:
				begin
					if (done)
						phase <= PH_JUDGE;   // Judge one cycle after last pixel
				end
				PH_JUDGE:
				begin
					phase <= PH_WAIT;
					// Misere rule, whoever made the line loses
					if (lost)
						result <= (turn == ttt_pkg::P1) ? ttt_pkg::P2_WINS : ttt_pkg::P1_WINS;
					else if (tie)
						result <= ttt_pkg::TIE;
					else
						turn <= (turn == ttt_pkg::P1) ? ttt_pkg::P2 : ttt_pkg::P1;
				end
				default:
					phase <= PH_WAIT;   // Unused code
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/board_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "ttt_defines.svh"

module board_store
(
	input  wire logic            clock,
	input  wire logic            resetn,
	input  wire logic            place,       // Write move into its cell
	input  wire ttt_pkg::move_t  move,
	output ttt_pkg::board_t      board,
	output logic                 cell_busy
);

	// Cells only ever fill up, a game never removes a tile
	always_ff @(posedge clock)
	begin
		if (!resetn)
			board <= '0;   // All EMPTY
		else if (place)
		begin
			for (int i = 0; i < `TTT_CELLS; i++)
			begin
				if (move.index == 4'(i))
					board[i].tile <= move.tile;
			end
		end
	end

	// Out of range index reads as busy so it can never be placed
	assign cell_busy = (move.index >= `TTT_CELLS)
		|| (board[move.index].tile != ttt_pkg::EMPTY);

endmodule

`default_nettype wire

// File: rtl/misere_judge.sv
`timescale 1ns/100ps
`default_nettype none

`include "ttt_defines.svh"

module misere_judge
(
	input  wire ttt_pkg::board_t board,
	output logic                 lost,   // Three red or three blue in a line
	output logic                 tie     // Full board and no such line
);

	localparam int LINES = 8;   // 3 rows, 3 columns, 2 diagonals

	ttt_pkg::cell_bits_t [LINES-1:0] line;   // Per line, colour bits ANDed
	logic                            full;

	function automatic ttt_pkg::cell_bits_t line_and(input ttt_pkg::cell_t a,
		input ttt_pkg::cell_t b, input ttt_pkg::cell_t c);
		ttt_pkg::cell_bits_t r;
		r.red  = a.bits.red & b.bits.red & c.bits.red;
		r.blue = a.bits.blue & b.bits.blue & c.bits.blue;
		return r;
	endfunction

	always_comb
	begin
		for (int k = 0; k < 3; k++)
		begin
			line[k]     = line_and(board[3*k], board[3*k+1], board[3*k+2]);   // Row k
			line[3 + k] = line_and(board[k], board[k+3], board[k+6]);         // Column k
		end
		line[6] = line_and(board[0], board[4], board[8]);   // Main diagonal
		line[7] = line_and(board[2], board[4], board[6]);   // Anti diagonal
	end

	always_comb
	begin
		lost = 1'b0;
		for (int k = 0; k < LINES; k++)
			lost = lost | line[k].red | line[k].blue;
	end

	// A cell is taken when either colour bit is set
	always_comb
	begin
		full = 1'b1;
		for (int i = 0; i < `TTT_CELLS; i++)
			full = full & (board[i].bits.red | board[i].bits.blue);
	end

	assign tie = full && !lost;   // A loss on the last cell is still a loss

endmodule

`default_nettype wire

// File: rtl/tile_plotter.sv
`timescale 1ns/100ps
`default_nettype none

`include "ttt_defines.svh"

module tile_plotter
(
	input  wire logic            clock,
	input  wire logic            resetn,
	input  wire logic            start,
	input  wire ttt_pkg::move_t  move,
	output ttt_pkg::plot_t       plot,
	output logic                 plot_valid,
	output logic                 done   // With the last pixel
);

	localparam int NPIX = `TTT_CELL_W * `TTT_CELL_H;   // 32 pixels
	localparam int XB   = $clog2(`TTT_CELL_W);           // Counter bits for x
	localparam int CB   = $clog2(NPIX);
	localparam int XW   = `TTT_X_W;
	localparam int YW   = `TTT_Y_W;

	logic [1:0]    row;
	logic [1:0]    col;
	logic [XW-1:0] base_x;   // Cell origin on screen
	logic [YW-1:0] base_y;
	logic [2:0]    colour;
	logic [CB-1:0] count;    // Low bits x, high bits y
	logic          busy;

	// Index to row and column of the 3x3 board
	assign row = (move.index >= 4'd6) ? 2'd2 : (move.index >= 4'd3) ? 2'd1 : 2'd0;
	assign col = 2'(move.index - 4'(row) * 4'd3);

	always_ff @(posedge clock)
	begin
		if (start)
		begin
			base_x <= `TTT_ORG_X + XW'(col) * `TTT_PITCH_X;
			base_y <= `TTT_ORG_Y + YW'(row) * `TTT_PITCH_Y;
			colour <= (move.tile == ttt_pkg::RED) ? `TTT_COL_RED : `TTT_COL_BLUE;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			busy  <= 1'b0;
			count <= '0;
		end
		else if (start)
		begin
			busy  <= 1'b1;   // First pixel next cycle
			count <= '0;
		end
		else if (busy)
		begin
			count <= count + 1'b1;   // Wraps to zero after the block
			if (done)
				busy <= 1'b0;
		end
	end

	// Row by row, x steps fastest
	assign plot.x      = base_x + XW'(count[XB-1:0]);
	assign plot.y      = base_y + YW'(count[CB-1:XB]);
	assign plot.colour = colour;
	assign plot_valid  = busy;
	assign done        = busy && (count == CB'(NPIX - 1));

endmodule

`default_nettype wire

// File: rtl/ttt_top.sv
`timescale 1ns/100ps
`default_nettype none

module ttt_top
(
	input  wire logic        clock,
	input  wire logic        resetn,
	input  wire logic [6:0]  key_code,
	input  wire logic        key_strobe,
	output ttt_pkg::plot_t   plot,
	output logic             plot_valid,
	output ttt_pkg::player_t turn,
	output ttt_pkg::result_t result
);

	ttt_pkg::move_t  pending;   // Cell and tile from the keys
	ttt_pkg::board_t board;
	logic            commit;
	logic            clear;
	logic            place;
	logic            start;
	logic            cell_busy;
	logic            lost;
	logic            tie;
	logic            done;

	key_decoder u_keys
	(
		.clock(clock), .resetn(resetn), .key_code(key_code), .key_strobe(key_strobe),
		.clear(clear), .pending(pending), .commit(commit)
	);

	// Sequencer, owns turn and result
	game_control u_ctrl
	(
		.clock(clock), .resetn(resetn), .commit(commit), .pending(pending),
		.cell_busy(cell_busy), .lost(lost), .tie(tie), .done(done), .place(place),
		.clear(clear), .start(start), .turn(turn), .result(result)
	);

	board_store u_board
	(
		.clock(clock), .resetn(resetn), .place(place), .move(pending),
		.board(board), .cell_busy(cell_busy)
	);

	misere_judge u_judge (.board(board), .lost(lost), .tie(tie));

	// Draws the pending move, latched on start
	tile_plotter u_plot
	(
		.clock(clock), .resetn(resetn), .start(start), .move(pending),
		.plot(plot), .plot_valid(plot_valid), .done(done)
	);

endmodule

`default_nettype wire

// File: bench/ttt_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "ttt_defines.svh"

module ttt_sva
(
	input  wire logic             clock,
	input  wire logic             resetn,
	input  wire logic             plot_valid,
	input  wire ttt_pkg::player_t turn,
	input  wire ttt_pkg::result_t result
);

	localparam int NPIX = `TTT_CELL_W * `TTT_CELL_H;   // Pixels per tile block

	int run;   // High cycles of plot_valid so far

	always_ff @(posedge clock)
	begin
		if (!resetn)
			run <= 0;
		else if (plot_valid)
			run <= run + 1;
		else
			run <= 0;   // Gap between blocks
	end

	// Never longer than one block
	a_block_long: assert property (@(posedge clock) disable iff (!resetn)
		plot_valid |-> run < NPIX)
		else $error("plot_valid stayed high past one tile block");

	// Never cut short
	a_block_short: assert property (@(posedge clock) disable iff (!resetn)
		(!plot_valid && run != 0) |-> run == NPIX)
		else $error("plot_valid dropped before the block was complete");

	// A finished game stays finished until reset
	a_result_held: assert property (@(posedge clock) disable iff (!resetn)
		(result != ttt_pkg::PLAYING) |=> $stable(result))
		else $error("result left its final value without reset");

	a_turn_held: assert property (@(posedge clock) disable iff (!resetn)
		plot_valid |=> $stable(turn))
		else $error("turn changed while a tile was drawn");   // Turn flips only after judging

endmodule

bind ttt_top ttt_sva u_sva
(
	.clock(clock), .resetn(resetn), .plot_valid(plot_valid), .turn(turn), .result(result)
);

`default_nettype wire

// File: bench/ttt_monitor.sv
`timescale 1ns/100ps
`default_nettype none

`include "ttt_defines.svh"

module ttt_monitor
(
	input  wire logic             clock,
	input  wire logic             resetn,
	input  wire ttt_pkg::plot_t   plot,
	input  wire logic             plot_valid,
	input  wire ttt_pkg::player_t turn,
	input  wire ttt_pkg::result_t result,
	input  wire logic             draw_expected,   // Model says a block is due
	input  wire ttt_pkg::move_t   exp_move,        // Cell and tile of that block
	input  wire logic             check,           // Compare turn and result this cycle
	input  wire ttt_pkg::player_t exp_turn,
	input  wire ttt_pkg::result_t exp_result,
	input  wire logic             game_done,
	output int                    error_count,
	output int                    check_count,
	output int                    game_count
);

	localparam int NPIX = `TTT_CELL_W * `TTT_CELL_H;
	localparam int XW   = `TTT_X_W;
	localparam int YW   = `TTT_Y_W;

	int       pix;     // Pixels seen in the current block
	int       moves;   // Blocks drawn this game
	int       row;
	int       col;
	logic [XW-1:0] want_x;
	logic [YW-1:0] want_y;
	logic [2:0]    want_c;

	initial
	begin
		error_count = 0;
		check_count = 0;
		game_count  = 0;
		pix         = 0;
		moves       = 0;
	end

	always @(posedge clock)
	begin
		if (resetn)
		begin
			if (plot_valid && !draw_expected)
			begin
				$display("Error at %0t: pixel plotted with no legal move entered", $time);
				error_count++;
			end
			else if (plot_valid)
			begin
				row    = exp_move.index / 3;   // Board is three cells wide
				col    = exp_move.index % 3;
				want_x = XW'(`TTT_ORG_X + col * `TTT_PITCH_X + pix % `TTT_CELL_W);
				want_y = YW'(`TTT_ORG_Y + row * `TTT_PITCH_Y + pix / `TTT_CELL_W);
				want_c = (exp_move.tile == ttt_pkg::RED) ? `TTT_COL_RED : `TTT_COL_BLUE;
				if (plot.x !== want_x || plot.y !== want_y || plot.colour !== want_c)
				begin
					$display("Error at %0t: pixel %0d at (%0d,%0d) colour %b, expected (%0d,%0d) %b",
						$time, pix, plot.x, plot.y, plot.colour, want_x, want_y, want_c);
					error_count++;
				end
				pix++;
			end
			else if (pix != 0)
			begin
				// Block just ended
				check_count++;
				if (pix != NPIX)
				begin
					$display("Error at %0t: block of %0d pixels, expected %0d", $time, pix, NPIX);
					error_count++;
				end
				pix = 0;
				moves++;
			end
			if (check)
			begin
				check_count++;
				if (turn !== exp_turn || result !== exp_result)
				begin
					$display("Error at %0t: turn %0d result %0d, expected turn %0d result %0d",
						$time, turn, result, exp_turn, exp_result);
					error_count++;
				end
			end
			if (game_done)
			begin
				game_count++;
				$display("Game %0d finished: %s after %0d moves", game_count, result.name(), moves);
				moves = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/ttt_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "ttt_defines.svh"

module ttt_tb;

	localparam int RANDOM_GAMES = 40;
	localparam int KEY_LIMIT    = 300;   // Keys per random game before giving up

	logic             clock;
	logic             resetn;
	logic [6:0]       key_code;
	logic             key_strobe;
	ttt_pkg::plot_t   plot;
	logic             plot_valid;
	ttt_pkg::player_t turn;
	ttt_pkg::result_t result;

	logic             draw_expected;   // Expectations for the monitor
	ttt_pkg::move_t   exp_move;
	logic             check;
	ttt_pkg::player_t exp_turn;
	ttt_pkg::result_t exp_result;
	logic             game_done;
	int               error_count;
	int               check_count;
	int               game_count;

	ttt_pkg::tile_t   m_board [`TTT_CELLS];   // Game model
	int               m_idx;
	logic             m_idx_v;
	ttt_pkg::tile_t   m_tile;
	logic             m_tile_v;
	ttt_pkg::player_t m_turn;
	ttt_pkg::result_t m_result;

	logic [31:0]      rng;
	logic             timed_out;

	ttt_top DUT
	(
		.clock(clock), .resetn(resetn), .key_code(key_code), .key_strobe(key_strobe),
		.plot(plot), .plot_valid(plot_valid), .turn(turn), .result(result)
	);

	ttt_monitor u_check
	(
		.clock(clock), .resetn(resetn), .plot(plot), .plot_valid(plot_valid), .turn(turn),
		.result(result), .draw_expected(draw_expected), .exp_move(exp_move), .check(check),
		.exp_turn(exp_turn), .exp_result(exp_result), .game_done(game_done),
		.error_count(error_count), .check_count(check_count), .game_count(game_count)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);   // xorshift32
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Three equal tiles, empty cells never count
	function automatic logic same3(input int a, input int b, input int c);
		return m_board[a] != ttt_pkg::EMPTY && m_board[a] == m_board[b]
			&& m_board[b] == m_board[c];
	endfunction

	function automatic logic line_done();
		logic hit;
		hit = same3(0, 4, 8) || same3(2, 4, 6);
		for (int k = 0; k < 3; k++)
			hit = hit || same3(3*k, 3*k+1, 3*k+2) || same3(k, k+3, k+6);   // Row, column
		return hit;
	endfunction

	function automatic logic board_full();
		logic full;
		full = 1'b1;
		foreach (m_board[i])
			if (m_board[i] == ttt_pkg::EMPTY)
				full = 1'b0;
		return full;
	endfunction

	function automatic logic [6:0] random_key();
		logic [31:0] r;
		r = next_rand();
		if (r[3:0] < 4'd8)
			return 7'(`TTT_KEY_ONE + r[15:8] % 9);
		else if (r[3:0] < 4'd10)
			return `TTT_KEY_R;
		else if (r[3:0] < 4'd12)
			return `TTT_KEY_B;
		else if (r[3:0] == 4'd12)
		begin
			case (r[17:16])   // Keys the game must ignore
				2'd0:    return 7'h78;   // 'x'
				2'd1:    return 7'h30;   // '0', just below the digits
				2'd2:    return 7'h52;   // 'R'
				default: return 7'h20;   // Space
			endcase
		end
		return `TTT_KEY_ENTER;
	endfunction

	// Sample at the falling edge, give up after limit cycles
	task automatic wait_plot(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clock);
		while (!timed_out && plot_valid !== level)
		begin
			if (n == limit)
			begin
				$display("Timeout: plot_valid did not reach %0b within %0d cycles at %0t",
					level, limit, $time);
				timed_out = 1'b1;
			end
			else
			begin
				@(negedge clock);
				n++;
			end
		end
	endtask

	task automatic request_check();
		@(posedge clock);
		exp_turn   <= m_turn;
		exp_result <= m_result;
		check      <= 1'b1;
		@(posedge clock);
		check      <= 1'b0;
	endtask

	// Board, then misere judgement on the new board
	task automatic apply_move();
		m_board[m_idx] = m_tile;
		m_idx_v  = 1'b0;
		m_tile_v = 1'b0;
		if (line_done())
			m_result = (m_turn == ttt_pkg::P1) ? ttt_pkg::P2_WINS : ttt_pkg::P1_WINS;
		else if (board_full())
			m_result = ttt_pkg::TIE;
		else
			m_turn = (m_turn == ttt_pkg::P1) ? ttt_pkg::P2 : ttt_pkg::P1;
	endtask

	task automatic press_key(input logic [6:0] code);
		logic legal;
		legal = 1'b0;
		if (code >= `TTT_KEY_ONE && code < `TTT_KEY_ONE + 7'd9)
		begin
			m_idx   = code - `TTT_KEY_ONE;
			m_idx_v = 1'b1;
		end
		else if (code == `TTT_KEY_R || code == `TTT_KEY_B)
		begin
			m_tile   = (code == `TTT_KEY_R) ? ttt_pkg::RED : ttt_pkg::BLUE;
			m_tile_v = 1'b1;
		end
		else if (code == `TTT_KEY_ENTER)
			legal = m_idx_v && m_tile_v && m_result == ttt_pkg::PLAYING
				&& m_board[m_idx] == ttt_pkg::EMPTY;
		@(posedge clock);
		key_code   <= code;
		key_strobe <= 1'b1;
		if (legal)
		begin
			exp_move.index <= 4'(m_idx);
			exp_move.tile  <= m_tile;
			draw_expected  <= 1'b1;
		end
		@(posedge clock);
		key_strobe <= 1'b0;
		if (legal)
		begin
			wait_plot(1'b1, 8);
			wait_plot(1'b0, 40);
			apply_move();
		end
		else
			repeat (4) @(posedge clock);   // Monitor flags any stray pixel meanwhile
		@(posedge clock);
		draw_expected <= 1'b0;
		request_check();
	endtask

	// Reset starts a new game, then the idle state is checked
	task automatic start_game();
		@(posedge clock);
		resetn <= 1'b0;
		repeat (2) @(posedge clock);
		resetn <= 1'b1;
		foreach (m_board[i])
			m_board[i] = ttt_pkg::EMPTY;
		m_idx_v  = 1'b0;
		m_tile_v = 1'b0;
		m_turn   = ttt_pkg::P1;
		m_result = ttt_pkg::PLAYING;
		repeat (3) @(posedge clock);
		request_check();
	endtask

	task automatic end_game();
		@(posedge clock);
		game_done <= 1'b1;
		@(posedge clock);
		game_done <= 1'b0;
	endtask

	task automatic play_script(input string keys);
		start_game();
		for (int i = 0; i < keys.len() && !timed_out; i++)
			press_key(7'(keys[i]));
		end_game();
	endtask

	task automatic play_random();
		int n;
		start_game();
		n = 0;
		while (m_result == ttt_pkg::PLAYING && n < KEY_LIMIT && !timed_out)
		begin
			press_key(random_key());
			n++;
		end
		end_game();
	endtask

	initial
	begin
		resetn        = 1'b0;
		key_code      = '0;
		key_strobe    = 1'b0;
		draw_expected = 1'b0;
		exp_move      = '0;
		check         = 1'b0;
		exp_turn      = ttt_pkg::P1;
		exp_result    = ttt_pkg::PLAYING;
		game_done     = 1'b0;
		rng           = 32'h3d19_542e;
		timed_out     = 1'b0;

		// Ignored Enters and keys, a busy cell, a red row, then Enter after the end
		play_script("\n7\nxb\n7r\n1r\n5b\n2r\n9b\n3r\n4r\n");
		// Full board with no line
		play_script("1r\n2b\n3r\n4r\n5b\n6b\n7b\n8r\n9r\n");
		for (int g = 0; g < RANDOM_GAMES && !timed_out; g++)
			play_random();

		@(negedge clock);
		$display("Games %0d, checks %0d, errors %0d", game_count, check_count, error_count);
		if (timed_out || error_count != 0)
			$display("TEST FAILED");
		else
			$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+rtl
rtl/ttt_pkg.sv
rtl/key_decoder.sv
rtl/game_control.sv
rtl/board_store.sv
rtl/misere_judge.sv
rtl/tile_plotter.sv
rtl/ttt_top.sv
bench/ttt_sva.sv
bench/ttt_monitor.sv
bench/ttt_tb.sv

// File: run.sh
#!/bin/bash
# Build with Verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
set -o pipefail
verilator --binary --timing --assert -Wno-fatal --top-module ttt_tb -f list.f -o ttt_sim \
	&& ./obj_dir/ttt_sim 2>&1 | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
echo "Simulation passed"
exit 0
